// ==== verilog/simd_isa_pkg.sv ====
`default_nettype none

package simd_isa_pkg;

    // Vector register and datapath sizes
    localparam int VLEN      = 128;
    localparam int ELEN      = 64;            // Width of one lane
    localparam int NUM_LANES = VLEN / ELEN;
    localparam int MAX_ELEMS = VLEN / 8;      // One mask bit per byte element
    localparam int XLEN      = 64;

    typedef enum logic [2:0] {
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VMUL,     // Low half of the product
        VMERGE,
        VMV_X_S   // Element 0 of vs2 to a scalar register
    } simd_op_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    // Where the second operand comes from
    typedef enum logic [1:0] {
        OPVV,
        OPVX,
        OPVI
    } opsrc_e;

endpackage

`default_nettype wire

// ==== verilog/simd_pipe_pkg.sv ====
`default_nettype none

package simd_pipe_pkg;

    import simd_isa_pkg::*;

    // Instruction from the scheduler
    typedef struct packed {
        logic                 valid;
        simd_op_e             op;
        sew_e                 sew;
        opsrc_e               src;
        logic                 use_mask;
        logic [4:0]           vd;
        logic [4:0]           rd;
        logic [XLEN-1:0]      rs1_data;
        logic [4:0]           imm;       // Sign-extended to the element width
        logic [VLEN-1:0]      vs1;
        logic [VLEN-1:0]      vs2;
        logic [VLEN-1:0]      old_vd;
        logic [MAX_ELEMS-1:0] vm;
    } simd_req_t;

    // Issued instruction carrying its unmasked result
    typedef struct packed {
        logic                 valid;
        simd_op_e             op;
        sew_e                 sew;
        logic                 use_mask;
        logic [4:0]           vd;
        logic [4:0]           rd;
        logic [VLEN-1:0]      raw_result;
        logic [VLEN-1:0]      fill;      // Value for masked-off elements
        logic [MAX_ELEMS-1:0] vm;
    } simd_stage_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      vd;
        logic [VLEN-1:0] vresult;
    } simd_vec_wb_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
    } simd_scalar_wb_t;

endpackage

`default_nettype wire

// ==== verilog/simd_lane_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_lane_alu
    import simd_isa_pkg::*;
(
    input  simd_op_e          op_i,
    input  sew_e              sew_i,
    input  logic [ELEN-1:0]   a_i,
    input  logic [ELEN-1:0]   b_i,
    output logic [ELEN-1:0]   y_o
);

    // One full-lane result per element width, indexed by sew_e
    logic [3:0][ELEN-1:0] res;

    for (genvar w = 0; w < 4; w++) begin : g_sew
        localparam int EW = 8 << w;

        for (genvar e = 0; e < ELEN / EW; e++) begin : g_elem
            logic [EW-1:0] ea;
            logic [EW-1:0] eb;
            logic [EW-1:0] ey;

            assign ea = a_i[e*EW +: EW];
            assign eb = b_i[e*EW +: EW];

            // Element-sized operands keep carries and products inside the element
            always_comb begin
                case (op_i)
                    VADD:    ey = ea + eb;
                    VSUB:    ey = ea - eb;
                    VAND:    ey = ea & eb;
                    VOR:     ey = ea | eb;
                    VXOR:    ey = ea ^ eb;
                    VMUL:    ey = ea * eb;   // Low EW bits only
                    default: ey = eb;
                endcase
            end

            assign res[w][e*EW +: EW] = ey;
        end
    end

    assign y_o = res[sew_i];

endmodule

`default_nettype wire

// ==== verilog/simd_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_issue_stage
    import simd_isa_pkg::*;
    import simd_pipe_pkg::*;
#(
    parameter int MUL_LATENCY   = 2,
    parameter int MUL64_LATENCY = 3
) (
    input  simd_req_t                              req_i,
    output simd_stage_t                            issued_o,
    output logic [$clog2(MUL64_LATENCY+1)-1:0]     lat_sel_o
);

    localparam int LAT_W = $clog2(MUL64_LATENCY + 1);

    logic [XLEN-1:0] scalar_src;
    logic [VLEN-1:0] scalar_rep;
    logic [VLEN-1:0] opb;
    logic [VLEN-1:0] lane_res;
    logic [VLEN-1:0] raw;

    // Immediate is sign-extended once, then truncated per element
    assign scalar_src = (req_i.src == OPVI) ? {{(XLEN-5){req_i.imm[4]}}, req_i.imm}
                                            : req_i.rs1_data;

    always_comb begin
        scalar_rep = '0;
        case (req_i.sew)
            SEW_8:  scalar_rep = {(VLEN/8){scalar_src[7:0]}};
            SEW_16: scalar_rep = {(VLEN/16){scalar_src[15:0]}};
            SEW_32: scalar_rep = {(VLEN/32){scalar_src[31:0]}};
            SEW_64: scalar_rep = {(VLEN/64){scalar_src[63:0]}};
        endcase
    end

    assign opb = (req_i.src == OPVV) ? req_i.vs1 : scalar_rep;

    // vd = vs2 op second operand
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        simd_lane_alu u_lane (
            .op_i  (req_i.op),
            .sew_i (req_i.sew),
            .a_i   (req_i.vs2[l*ELEN +: ELEN]),
            .b_i   (opb[l*ELEN +: ELEN]),
            .y_o   (lane_res[l*ELEN +: ELEN])
        );
    end

    always_comb begin
        case (req_i.op)
            VMERGE:  raw = opb;
            VMV_X_S: raw = req_i.vs2;    // Element 0 is picked at writeback
            default: raw = lane_res;
        endcase
    end

    always_comb begin
        issued_o            = '0;
        issued_o.valid      = req_i.valid;
        issued_o.op         = req_i.op;
        issued_o.sew        = req_i.sew;
        issued_o.use_mask   = req_i.use_mask;
        issued_o.vd         = req_i.vd;
        issued_o.rd         = req_i.rd;
        issued_o.raw_result = raw;
        issued_o.fill       = (req_i.op == VMERGE) ? req_i.vs2 : req_i.old_vd;
        issued_o.vm         = req_i.vm;
    end

    // Completion latency in cycles
    always_comb begin
        if (req_i.op == VMUL) begin
            lat_sel_o = (req_i.sew == SEW_64) ? LAT_W'(MUL64_LATENCY) : LAT_W'(MUL_LATENCY);
        end else begin
            lat_sel_o = LAT_W'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/simd_latency_lines.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_latency_lines
    import simd_pipe_pkg::*;
#(
    parameter int MUL64_LATENCY = 3
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  simd_stage_t                            issued_i,
    input  logic [$clog2(MUL64_LATENCY+1)-1:0]     lat_sel_i,
    output simd_stage_t                            done_o
);

    localparam int LAT_W = $clog2(MUL64_LATENCY + 1);

    simd_stage_t                tail [1:MUL64_LATENCY];   // Last slot of each line
    logic [MUL64_LATENCY:1]     tail_valid;

    // Line k is k slots deep, so an entry leaves it k cycles after issue
    for (genvar k = 1; k <= MUL64_LATENCY; k++) begin : g_line
        simd_stage_t slot_q [0:k-1];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j < k; j++) begin
                    slot_q[j] <= '0;
                end
            end else begin
                if (issued_i.valid && (lat_sel_i == LAT_W'(k))) begin
                    slot_q[0] <= issued_i;
                end else begin
                    slot_q[0] <= '0;
                end
                for (int j = 1; j < k; j++) begin
                    slot_q[j] <= slot_q[j-1];
                end
            end
        end

        assign tail[k]       = slot_q[k-1];
        assign tail_valid[k] = slot_q[k-1].valid;
    end

    // Lowest-numbered completing line wins
    always_comb begin
        done_o = '0;
        for (int k = MUL64_LATENCY; k >= 1; k--) begin
            if (tail_valid[k]) begin
                done_o = tail[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/simd_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_writeback
    import simd_isa_pkg::*;
    import simd_pipe_pkg::*;
(
    input  simd_stage_t        done_i,
    output simd_vec_wb_t       vec_wb_o,
    output simd_scalar_wb_t    scalar_wb_o
);

    logic [VLEN-1:0] bit_en;      // Per-bit copy of the element mask
    logic [VLEN-1:0] merged;
    logic [XLEN-1:0] scalar_res;
    logic            is_mv;

    // Element i owns mask bit i at every SEW
    always_comb begin
        bit_en = '1;
        if (done_i.use_mask) begin
            for (int i = 0; i < VLEN; i++) begin
                case (done_i.sew)
                    SEW_8:  bit_en[i] = done_i.vm[i/8];
                    SEW_16: bit_en[i] = done_i.vm[i/16];
                    SEW_32: bit_en[i] = done_i.vm[i/32];
                    SEW_64: bit_en[i] = done_i.vm[i/64];
                endcase
            end
        end
    end

    assign merged = (done_i.raw_result & bit_en) | (done_i.fill & ~bit_en);

    always_comb begin
        scalar_res = '0;
        case (done_i.sew)
            SEW_8:  scalar_res = {{(XLEN-8){done_i.raw_result[7]}}, done_i.raw_result[7:0]};
            SEW_16: scalar_res = {{(XLEN-16){done_i.raw_result[15]}}, done_i.raw_result[15:0]};
            SEW_32: scalar_res = {{(XLEN-32){done_i.raw_result[31]}}, done_i.raw_result[31:0]};
            SEW_64: scalar_res = done_i.raw_result[XLEN-1:0];
        endcase
    end

    assign is_mv = (done_i.op == VMV_X_S);

    assign vec_wb_o.valid   = done_i.valid & ~is_mv;
    assign vec_wb_o.vd      = done_i.vd;
    assign vec_wb_o.vresult = merged;

    assign scalar_wb_o.valid  = done_i.valid & is_mv;
    assign scalar_wb_o.rd     = done_i.rd;
    assign scalar_wb_o.result = scalar_res;

endmodule

`default_nettype wire

// ==== verilog/simd_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_exec_unit
    import simd_pipe_pkg::*;
#(
    parameter int MUL_LATENCY   = 2,
    parameter int MUL64_LATENCY = 3
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  simd_req_t          req_i,
    output simd_vec_wb_t       vec_wb_o,
    output simd_scalar_wb_t    scalar_wb_o
);

    simd_stage_t                                issued;
    simd_stage_t                                done;
    logic [$clog2(MUL64_LATENCY+1)-1:0]         lat_sel;

    simd_issue_stage #(
        .MUL_LATENCY   (MUL_LATENCY),
        .MUL64_LATENCY (MUL64_LATENCY)
    ) u_issue (
        .req_i     (req_i),
        .issued_o  (issued),
        .lat_sel_o (lat_sel)
    );

    simd_latency_lines #(
        .MUL64_LATENCY (MUL64_LATENCY)
    ) u_lines (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .issued_i  (issued),
        .lat_sel_i (lat_sel),
        .done_o    (done)
    );

    simd_writeback u_wb (
        .done_i      (done),
        .vec_wb_o    (vec_wb_o),
        .scalar_wb_o (scalar_wb_o)
    );

endmodule

`default_nettype wire

// ==== verification/simd_tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD = 5;   // 10 ns clock

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/simd_exec_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_exec_unit_properties #(
    parameter int MUL64_LATENCY = 3
) (
    input logic                     clk_i,
    input logic                     rstn_i,
    input logic                     vec_valid_i,
    input logic                     scalar_valid_i,
    input logic [MUL64_LATENCY:1]   tail_valid_i
);

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> (!vec_valid_i && !scalar_valid_i))
        else $error("Writeback valid high during reset");

    a_one_port: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(vec_valid_i && scalar_valid_i))
        else $error("Vector and scalar writeback valid together");

    // Scheduler must keep completions apart
    a_one_completion: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(tail_valid_i))
        else $error("Two latency lines complete in the same cycle");

endmodule

bind simd_exec_unit simd_exec_unit_properties #(
    .MUL64_LATENCY (MUL64_LATENCY)
) u_props (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .vec_valid_i    (vec_wb_o.valid),
    .scalar_valid_i (scalar_wb_o.valid),
    .tail_valid_i   (u_lines.tail_valid)
);

`default_nettype wire

// ==== verification/simd_exec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_exec_unit_tb
    import simd_isa_pkg::*;
    import simd_pipe_pkg::*;
();

    localparam int MUL_LATENCY    = 2;
    localparam int MUL64_LATENCY  = 3;
    localparam int TIMEOUT_CYCLES = 5000;   // Generous bound on the total test length

    logic            clk;
    logic            rstn;
    simd_req_t       req;
    simd_vec_wb_t    vec_wb;
    simd_scalar_wb_t scalar_wb;
    int unsigned     cycle = 0;
    logic [31:0]     seed  = 32'ha648ca37;

    simd_tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    simd_exec_unit #(
        .MUL_LATENCY   (MUL_LATENCY),
        .MUL64_LATENCY (MUL64_LATENCY)
    ) dut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_i       (req),
        .vec_wb_o    (vec_wb),
        .scalar_wb_o (scalar_wb)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) abort_run("Timeout: the tests did not finish in time");
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic simd_req_t rand_req(simd_op_e op, sew_e sew, opsrc_e src);
        simd_req_t   r;
        logic [31:0] tmp;
        tmp = next_rand();
        r = '0;
        r.valid    = 1'b1;
        r.op       = op;
        r.sew      = sew;
        r.src      = src;
        r.vd       = tmp[4:0];
        r.rd       = tmp[9:5];
        r.imm      = tmp[14:10];
        r.vm       = tmp[31:16];
        r.rs1_data = {next_rand(), next_rand()};
        r.vs1      = {next_rand(), next_rand(), next_rand(), next_rand()};
        r.vs2      = {next_rand(), next_rand(), next_rand(), next_rand()};
        r.old_vd   = {next_rand(), next_rand(), next_rand(), next_rand()};
        return r;
    endfunction

    function automatic int unsigned ref_lat(simd_req_t r);
        if (r.op != VMUL) return 1;
        return (r.sew == SEW_64) ? MUL64_LATENCY : MUL_LATENCY;
    endfunction

    // Expected vector: vd[i] = vs2[i] op operand[i], masked per element
    function automatic logic [VLEN-1:0] ref_vec(simd_req_t r);
        int              ew;
        logic [63:0]     msk;
        logic [63:0]     scal;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     y;
        logic [VLEN-1:0] wide;
        logic [VLEN-1:0] res;
        ew   = 8 << r.sew;
        msk  = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        scal = (r.src == OPVI) ? {{59{r.imm[4]}}, r.imm} : r.rs1_data;
        res  = '0;
        for (int i = 0; i < VLEN / ew; i++) begin
            wide = r.vs2 >> (i * ew);
            a = wide[63:0] & msk;
            wide = r.vs1 >> (i * ew);
            b = ((r.src == OPVV) ? wide[63:0] : scal) & msk;
            case (r.op)
                VADD:    y = a + b;
                VSUB:    y = a - b;
                VAND:    y = a & b;
                VOR:     y = a | b;
                VXOR:    y = a ^ b;
                VMUL:    y = a * b;
                default: y = b;   // VMERGE
            endcase
            if (r.use_mask && !r.vm[i]) begin
                wide = r.old_vd >> (i * ew);
                y = (r.op == VMERGE) ? a : wide[63:0];
            end
            res = res | ({64'd0, y & msk} << (i * ew));
        end
        return res;
    endfunction

    function automatic logic [XLEN-1:0] ref_scalar(simd_req_t r);
        int          ew;
        logic [63:0] msk;
        logic [63:0] t;
        ew  = 8 << r.sew;
        msk = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        t   = r.vs2[63:0] & msk;
        if (t[ew-1]) t = t | ~msk;   // Sign extension
        return t;
    endfunction

    task automatic check_vec(input string name, input simd_vec_wb_t exp, input simd_vec_wb_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_scalar(input string name, input simd_scalar_wb_t exp,
                                input simd_scalar_wb_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h actual %h", name, exp, act));
    endtask

    // Strobe on the next rising edge; returns that edge's number
    task automatic issue(input simd_req_t r, output int unsigned t_drv);
        @(negedge clk);
        t_drv = cycle + 1;
        @(posedge clk);
        req <= r;
    endtask

    task automatic wait_and_check(input string name, input simd_req_t r, input int unsigned t_drv);
        int unsigned     t_exp;
        logic            is_scalar;
        logic            seen;
        simd_vec_wb_t    exp_vec;
        simd_scalar_wb_t exp_sc;
        t_exp     = t_drv + ref_lat(r);
        is_scalar = (r.op == VMV_X_S);
        seen      = 1'b0;
        while (!seen) begin
            @(posedge clk);
            req.valid <= 1'b0;
            @(negedge clk);
            if (is_scalar ? vec_wb.valid : scalar_wb.valid)
                abort_run($sformatf("%s: writeback appeared on the wrong port", name));
            seen = is_scalar ? scalar_wb.valid : vec_wb.valid;
            if (!seen && cycle >= t_exp)
                abort_run($sformatf("%s: no writeback by its completion cycle", name));
        end
        if (cycle != t_exp)
            abort_run($sformatf("ERR %s: completion cycle expected %0d actual %0d",
                                name, t_exp, cycle));
        if (is_scalar) begin
            exp_sc = '{valid: 1'b1, rd: r.rd, result: ref_scalar(r)};
            check_scalar(name, exp_sc, scalar_wb);
        end else begin
            exp_vec = '{valid: 1'b1, vd: r.vd, vresult: ref_vec(r)};
            check_vec(name, exp_vec, vec_wb);
        end
    endtask

    task automatic test_reset();
        repeat (6) begin
            @(negedge clk);
            if (vec_wb.valid !== 1'b0 || scalar_wb.valid !== 1'b0)
                abort_run("Writeback valid not low around reset");
        end
    endtask

    task automatic test_alu_ops();
        simd_op_e    ops [5] = '{VADD, VSUB, VAND, VOR, VXOR};
        opsrc_e      srcs [3] = '{OPVV, OPVX, OPVI};
        simd_op_e    op;
        sew_e        sew;
        opsrc_e      src;
        simd_req_t   r;
        int unsigned t;
        for (int o = 0; o < 5; o++) begin
            for (int s = 0; s < 4; s++) begin
                for (int k = 0; k < 3; k++) begin
                    op  = ops[o];
                    sew = sew_e'(s);
                    src = srcs[k];
                    r = rand_req(op, sew, src);
                    issue(r, t);
                    wait_and_check($sformatf("alu %s %s %s", op.name(), sew.name(), src.name()),
                                   r, t);
                end
            end
        end
    endtask

    task automatic test_mul_latency();
        simd_req_t   r;
        simd_req_t   r_alu;
        int unsigned t;
        int unsigned t_alu;
        for (int s = 0; s < 4; s++) begin
            r = rand_req(VMUL, sew_e'(s), OPVV);
            issue(r, t);
            wait_and_check($sformatf("mul sew %0d", s), r, t);
        end
        // Long multiply overtaken by a following ALU op
        r     = rand_req(VMUL, SEW_64, OPVV);
        r_alu = rand_req(VADD, SEW_32, OPVX);
        issue(r, t);
        issue(r_alu, t_alu);
        wait_and_check("overlap add", r_alu, t_alu);
        wait_and_check("overlap mul64", r, t);
    endtask

    task automatic test_mask_merge();
        simd_op_e    ops [4] = '{VADD, VMUL, VMERGE, VMERGE};
        opsrc_e      srcs [4] = '{OPVV, OPVI, OPVV, OPVX};
        simd_req_t   r;
        int unsigned t;
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 4; k++) begin
                r = rand_req(ops[k], sew_e'(s), srcs[k]);
                r.use_mask = 1'b1;
                issue(r, t);
                wait_and_check($sformatf("mask case %0d sew %0d", k, s), r, t);
            end
        end
    endtask

    task automatic test_scalar_move();
        simd_req_t   r;
        int unsigned t;
        for (int s = 0; s < 4; s++) begin
            r = rand_req(VMV_X_S, sew_e'(s), OPVV);
            issue(r, t);
            wait_and_check($sformatf("vmv.x.s sew %0d", s), r, t);
            r.vs2 = ~r.vs2;   // Other sign of element 0
            issue(r, t);
            wait_and_check($sformatf("vmv.x.s inv sew %0d", s), r, t);
        end
    endtask

    initial begin
        req = '0;
        test_reset();
        test_alu_ops();
        test_mul_latency();
        test_mask_merge();
        test_scalar_move();
        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/simd_isa_pkg.sv
verilog/simd_pipe_pkg.sv
verilog/simd_lane_alu.sv
verilog/simd_issue_stage.sv
verilog/simd_latency_lines.sv
verilog/simd_writeback.sv
verilog/simd_exec_unit.sv
verification/simd_tb_clkgen.sv
verification/simd_exec_unit_properties.sv
verification/simd_exec_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module simd_exec_unit_tb -o simd_sim
./obj_dir/simd_sim 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
# An assertion stop ends the run without any final message
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi
